// ==== verilog/opu_pkg.sv ====
package opu_pkg;

  // word and register number widths, fixed by the command format
  localparam int data_w = 32;
  localparam int reg_num_w = 4;

  // register 15 is the instruction pointer
  localparam logic [reg_num_w-1:0] ip_reg = 4'd15;

  // operand slots, in fetch order
  typedef enum logic [1:0] {
    slot_cond = 2'd0,
    slot_src1 = 2'd1,
    slot_src0 = 2'd2
  } slot_e;

  // post-update flag, keep behaves like none
  typedef enum logic [1:0] {
    flag_none = 2'd0,
    flag_inc  = 2'd1,
    flag_dec  = 2'd2,
    flag_keep = 2'd3
  } flag_e;

  // per-slot decode
  typedef struct packed {
    logic [reg_num_w-1:0] num;
    logic                 ptr;
    flag_e                flag;
    // register value taken from an earlier slot
    logic                 fwd;
    slot_e                src;
  } operand_ctl_t;

  // decoded command word, opnd indexed by slot_e
  typedef struct packed {
    logic [3:0]             opcode;
    operand_ctl_t [2:0]     opnd;
    logic [reg_num_w-1:0]   dst_num;
    logic                   dst_ptr;
    flag_e                  dst_flag;
  } cmd_fields_t;

  // what the execute side sees
  typedef struct packed {
    logic [3:0]        opcode;
    logic [data_w-1:0] cond;
    logic [data_w-1:0] src1;
    logic [data_w-1:0] src0;
  } operands_t;

  // memory request, strobes are single-cycle
  typedef struct packed {
    logic              rd;
    logic              wr;
    logic [data_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } mem_req_t;

  typedef enum logic [3:0] {
    st_idle,
    st_ip_rd,
    st_cmd_rd,
    st_ip_wr,
    st_reg_rd,
    st_ptr_rd,
    st_present,
    st_wait_res,
    st_d_rd,
    st_res_wr,
    st_dst_wr,
    st_upd_wr
  } opu_state_e;

  // data path operation for the current cycle
  typedef enum logic [2:0] {
    op_ip_rd,
    op_cmd_rd,
    op_ip_wr,
    op_reg_rd,
    op_ptr_rd,
    op_d_rd,
    op_res_wr,
    op_upd_wr
  } store_op_e;

endpackage

// ==== verilog/slot_counter.sv ====
`timescale 1ns/1ps

module slot_counter (
  input  logic           clk,
  input  logic           rst,
  input  logic           slot_step,
  input  logic           slot_clear,
  output opu_pkg::slot_e slot,
  output logic           slot_last
);

  // cond, src1, src0, then back to cond
  always_ff @(posedge clk) begin
    if (rst || slot_clear) begin
      slot <= opu_pkg::slot_cond;
    end else if (slot_step) begin
      case (slot)
        opu_pkg::slot_cond: slot <= opu_pkg::slot_src1;
        opu_pkg::slot_src1: slot <= opu_pkg::slot_src0;
        default:            slot <= opu_pkg::slot_cond;
      endcase
    end
  end

  // src0 closes both the fetch and update pass
  assign slot_last = (slot == opu_pkg::slot_src0);

endmodule

// ==== verilog/cmd_decoder.sv ====
`timescale 1ns/1ps

module cmd_decoder (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        capture,
  input  logic [opu_pkg::data_w-1:0]  rdata,
  output opu_pkg::cmd_fields_t        fields
);

  logic [opu_pkg::data_w-1:0] cmd_q;

  always_ff @(posedge clk) begin
    if (rst)
      cmd_q <= '0;
    else if (capture)
      cmd_q <= rdata;
  end

  always_comb begin
    fields.opcode = cmd_q[31:28];
    // register numbers
    fields.opnd[opu_pkg::slot_src1].num = cmd_q[3:0];
    fields.opnd[opu_pkg::slot_src0].num = cmd_q[7:4];
    fields.dst_num                      = cmd_q[11:8];
    fields.opnd[opu_pkg::slot_cond].num = cmd_q[15:12];
    // pointer bits
    fields.opnd[opu_pkg::slot_src1].ptr = cmd_q[16];
    fields.opnd[opu_pkg::slot_src0].ptr = cmd_q[17];
    fields.dst_ptr                      = cmd_q[18];
    fields.opnd[opu_pkg::slot_cond].ptr = cmd_q[19];
    // two-bit update flags
    fields.opnd[opu_pkg::slot_src1].flag = opu_pkg::flag_e'(cmd_q[21:20]);
    fields.opnd[opu_pkg::slot_src0].flag = opu_pkg::flag_e'(cmd_q[23:22]);
    fields.dst_flag                      = opu_pkg::flag_e'(cmd_q[25:24]);
    fields.opnd[opu_pkg::slot_cond].flag = opu_pkg::flag_e'(cmd_q[27:26]);
    // cond is first and never forwarded
    fields.opnd[opu_pkg::slot_cond].fwd = 1'b0;
    fields.opnd[opu_pkg::slot_cond].src = opu_pkg::slot_cond;
    fields.opnd[opu_pkg::slot_src1].fwd = (cmd_q[3:0] == cmd_q[15:12]);
    fields.opnd[opu_pkg::slot_src1].src = opu_pkg::slot_cond;
    // src0 prefers cond, then src1
    fields.opnd[opu_pkg::slot_src0].fwd = (cmd_q[7:4] == cmd_q[15:12]) ||
                                          (cmd_q[7:4] == cmd_q[3:0]);
    fields.opnd[opu_pkg::slot_src0].src = (cmd_q[7:4] == cmd_q[15:12]) ?
                                          opu_pkg::slot_cond : opu_pkg::slot_src1;
  end

endmodule

// ==== verilog/operand_store.sv ====
`timescale 1ns/1ps

module operand_store (
  input  logic                        clk,
  input  logic                        rst,
  input  opu_pkg::store_op_e          store_op,
  input  opu_pkg::slot_e              slot,
  input  opu_pkg::cmd_fields_t        fields,
  input  logic [opu_pkg::data_w-1:0]  base_addr,
  input  logic [opu_pkg::data_w-1:0]  rdata,
  input  logic                        capture,
  input  logic [opu_pkg::data_w-1:0]  result,
  input  logic                        result_valid,
  output opu_pkg::operands_t          operands,
  output logic [opu_pkg::data_w-1:0]  mem_addr,
  output logic [opu_pkg::data_w-1:0]  mem_wdata
);

  logic [opu_pkg::data_w-1:0] ip_q;
  logic [opu_pkg::data_w-1:0] d_q;
  logic [opu_pkg::data_w-1:0] res_q;
  logic [opu_pkg::data_w-1:0] reg_q [3];
  logic [opu_pkg::data_w-1:0] opnd_q [3];
  logic [opu_pkg::data_w-1:0] dst_addr;
  logic                       dst_pend;
  opu_pkg::operand_ctl_t      ctl;

  function automatic logic [opu_pkg::data_w-1:0] bump(input logic [opu_pkg::data_w-1:0] v,
                                                      input opu_pkg::flag_e f);
    case (f)
      opu_pkg::flag_inc: return v + 1'b1;
      opu_pkg::flag_dec: return v - 1'b1;
      default:           return v;
    endcase
  endfunction

  assign ctl = fields.opnd[slot];
  assign dst_addr = base_addr + opu_pkg::data_w'(fields.dst_num);

  // address and write data per op
  always_comb begin
    mem_addr = base_addr + opu_pkg::data_w'(opu_pkg::ip_reg);
    mem_wdata = res_q;
    case (store_op)
      opu_pkg::op_cmd_rd: mem_addr = ip_q;
      opu_pkg::op_ip_wr:  mem_wdata = ip_q + 1'b1;
      opu_pkg::op_reg_rd: mem_addr = base_addr + opu_pkg::data_w'(ctl.num);
      opu_pkg::op_ptr_rd: mem_addr = reg_q[slot];
      opu_pkg::op_d_rd:   mem_addr = dst_addr;
      // through D when it is a pointer
      opu_pkg::op_res_wr: mem_addr = fields.dst_ptr ? d_q : dst_addr;
      opu_pkg::op_upd_wr: begin
        if (dst_pend) begin
          mem_addr = dst_addr;
          mem_wdata = bump(fields.dst_ptr ? d_q : res_q, fields.dst_flag);
        end else begin
          mem_addr = base_addr + opu_pkg::data_w'(ctl.num);
          mem_wdata = bump(reg_q[slot], ctl.flag);
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      case (store_op)
        opu_pkg::op_ip_rd: ip_q <= rdata;
        // direct operand until a pointer read replaces it
        opu_pkg::op_reg_rd: begin
          reg_q[slot] <= rdata;
          opnd_q[slot] <= rdata;
        end
        opu_pkg::op_ptr_rd: opnd_q[slot] <= rdata;
        opu_pkg::op_d_rd:   d_q <= rdata;
        default: ;
      endcase
    end else if (store_op == opu_pkg::op_reg_rd && ctl.fwd) begin
      // forwarded slot, no memory read
      reg_q[slot] <= reg_q[ctl.src];
      opnd_q[slot] <= reg_q[ctl.src];
    end
    if (result_valid)
      res_q <= result;
  end

  // dst update goes out before the slot updates
  always_ff @(posedge clk) begin
    if (rst)
      dst_pend <= 1'b0;
    else if (result_valid)
      dst_pend <= fields.dst_flag inside {opu_pkg::flag_inc, opu_pkg::flag_dec};
    else if (capture && store_op == opu_pkg::op_upd_wr)
      dst_pend <= 1'b0;
  end

  always_comb begin
    operands.opcode = fields.opcode;
    operands.cond = opnd_q[opu_pkg::slot_cond];
    operands.src1 = opnd_q[opu_pkg::slot_src1];
    operands.src0 = opnd_q[opu_pkg::slot_src0];
  end

endmodule

// ==== verilog/mem_port.sv ====
`timescale 1ns/1ps

module mem_port (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        go,
  input  opu_pkg::store_op_e          store_op,
  input  logic [opu_pkg::data_w-1:0]  addr,
  input  logic [opu_pkg::data_w-1:0]  wdata,
  output opu_pkg::mem_req_t           mem_req,
  input  logic                        read_dn,
  input  logic                        write_dn,
  output logic                        done
);

  logic                       is_read;
  logic                       rd_q;
  logic                       wr_q;
  logic                       pend_q;
  logic                       pend_rd_q;
  logic [opu_pkg::data_w-1:0] addr_q;
  logic [opu_pkg::data_w-1:0] wdata_q;

  assign is_read = store_op inside {opu_pkg::op_ip_rd, opu_pkg::op_cmd_rd,
                                    opu_pkg::op_reg_rd, opu_pkg::op_ptr_rd,
                                    opu_pkg::op_d_rd};

  // only the done of the outstanding kind counts
  assign done = pend_q && (pend_rd_q ? read_dn : write_dn);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q <= 1'b0;
      wr_q <= 1'b0;
      pend_q <= 1'b0;
      pend_rd_q <= 1'b0;
    end else begin
      // strobe one cycle after go
      rd_q <= go && is_read;
      wr_q <= go && !is_read;
      if (go) begin
        pend_q <= 1'b1;
        pend_rd_q <= is_read;
      end else if (done) begin
        pend_q <= 1'b0;
      end
    end
  end

  // held stable until the matching done
  always_ff @(posedge clk) begin
    if (go) begin
      addr_q <= addr;
      wdata_q <= wdata;
    end
  end

  always_comb begin
    mem_req.rd = rd_q;
    mem_req.wr = wr_q;
    mem_req.addr = addr_q;
    mem_req.wdata = wdata_q;
  end

endmodule

// ==== verilog/opu_sequencer.sv ====
`timescale 1ns/1ps

module opu_sequencer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  output logic                  busy,
  output logic                  done,
  output logic                  operands_valid,
  input  opu_pkg::cmd_fields_t  fields,
  input  opu_pkg::slot_e        slot,
  input  logic                  slot_last,
  output logic                  slot_step,
  output logic                  slot_clear,
  output opu_pkg::store_op_e    store_op,
  output logic                  mem_go,
  input  logic                  mem_done,
  input  logic                  result_valid
);

  opu_pkg::opu_state_e   state_q;
  opu_pkg::opu_state_e   state_d;
  opu_pkg::operand_ctl_t ctl;
  logic                  issued_q;
  logic                  need_mem;
  logic                  adv;
  logic                  upd_ok;
  logic                  dst_upd;
  logic                  finish;

  // decode of the slot currently being worked on
  assign ctl = fields.opnd[slot];

  // no slot update lands on register D, keep acts as none
  assign upd_ok = (ctl.flag inside {opu_pkg::flag_inc, opu_pkg::flag_dec}) &&
                  (ctl.num != fields.dst_num);
  assign dst_upd = fields.dst_flag inside {opu_pkg::flag_inc, opu_pkg::flag_dec};

  // states that own a memory access this cycle
  always_comb begin
    case (state_q)
      opu_pkg::st_ip_rd, opu_pkg::st_cmd_rd, opu_pkg::st_ip_wr, opu_pkg::st_ptr_rd,
      opu_pkg::st_d_rd, opu_pkg::st_res_wr, opu_pkg::st_dst_wr: need_mem = 1'b1;
      // forwarded slot copies internally
      opu_pkg::st_reg_rd: need_mem = !ctl.fwd;
      opu_pkg::st_upd_wr: need_mem = upd_ok;
      default:            need_mem = 1'b0;
    endcase
  end

  // one go per access, first cycle in the state
  assign mem_go = need_mem && !issued_q;
  assign adv = !need_mem || mem_done;

  always_comb begin
    case (state_q)
      opu_pkg::st_cmd_rd: store_op = opu_pkg::op_cmd_rd;
      opu_pkg::st_ip_wr:  store_op = opu_pkg::op_ip_wr;
      opu_pkg::st_reg_rd: store_op = opu_pkg::op_reg_rd;
      opu_pkg::st_ptr_rd: store_op = opu_pkg::op_ptr_rd;
      opu_pkg::st_d_rd:   store_op = opu_pkg::op_d_rd;
      opu_pkg::st_res_wr: store_op = opu_pkg::op_res_wr;
      // dst update and slot updates share the write op
      opu_pkg::st_dst_wr, opu_pkg::st_upd_wr: store_op = opu_pkg::op_upd_wr;
      default:            store_op = opu_pkg::op_ip_rd;
    endcase
  end

  always_comb begin
    state_d = state_q;
    slot_step = 1'b0;
    slot_clear = 1'b0;
    finish = 1'b0;
    case (state_q)
      opu_pkg::st_idle: begin
        if (start) begin
          state_d = opu_pkg::st_ip_rd;
          slot_clear = 1'b1;
        end
      end
      opu_pkg::st_ip_rd:  if (adv) state_d = opu_pkg::st_cmd_rd;
      opu_pkg::st_cmd_rd: if (adv) state_d = opu_pkg::st_ip_wr;
      opu_pkg::st_ip_wr:  if (adv) state_d = opu_pkg::st_reg_rd;
      opu_pkg::st_reg_rd: begin
        if (adv) begin
          if (ctl.ptr)
            state_d = opu_pkg::st_ptr_rd;
          else if (slot_last)
            state_d = opu_pkg::st_present;
          else
            slot_step = 1'b1;
        end
      end
      opu_pkg::st_ptr_rd: begin
        if (adv) begin
          if (slot_last) begin
            state_d = opu_pkg::st_present;
          end else begin
            state_d = opu_pkg::st_reg_rd;
            slot_step = 1'b1;
          end
        end
      end
      // single cycle, rewind slots for the update pass
      opu_pkg::st_present: begin
        state_d = opu_pkg::st_wait_res;
        slot_clear = 1'b1;
      end
      opu_pkg::st_wait_res: begin
        if (result_valid)
          state_d = fields.dst_ptr ? opu_pkg::st_d_rd : opu_pkg::st_res_wr;
      end
      opu_pkg::st_d_rd:   if (adv) state_d = opu_pkg::st_res_wr;
      opu_pkg::st_res_wr: begin
        if (adv)
          state_d = dst_upd ? opu_pkg::st_dst_wr : opu_pkg::st_upd_wr;
      end
      opu_pkg::st_dst_wr: if (adv) state_d = opu_pkg::st_upd_wr;
      opu_pkg::st_upd_wr: begin
        if (adv) begin
          if (slot_last) begin
            state_d = opu_pkg::st_idle;
            finish = 1'b1;
          end else begin
            slot_step = 1'b1;
          end
        end
      end
      default: state_d = opu_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= opu_pkg::st_idle;
      issued_q <= 1'b0;
      done <= 1'b0;
    end else begin
      state_q <= state_d;
      // done lines up with the return to idle
      done <= finish;
      if (mem_go)
        issued_q <= 1'b1;
      else if (mem_done)
        issued_q <= 1'b0;
    end
  end

  assign busy = (state_q != opu_pkg::st_idle);
  assign operands_valid = (state_q == opu_pkg::st_present);

endmodule

// ==== verilog/operand_unit.sv ====
`timescale 1ns/1ps

module operand_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start,
  input  logic [opu_pkg::data_w-1:0]    base_addr,
  output opu_pkg::mem_req_t             mem_req,
  input  logic                          read_dn,
  input  logic                          write_dn,
  input  logic [opu_pkg::data_w-1:0]    rdata,
  output logic                          busy,
  output logic                          done,
  output logic                          operands_valid,
  output opu_pkg::operands_t            operands,
  input  logic [opu_pkg::data_w-1:0]    result,
  input  logic                          result_valid
);

  opu_pkg::cmd_fields_t          fields;
  opu_pkg::slot_e                slot;
  opu_pkg::store_op_e            store_op;
  logic                          slot_last;
  logic                          slot_step;
  logic                          slot_clear;
  logic                          mem_go;
  logic                          mem_done;
  logic                          cmd_capture;
  logic [opu_pkg::data_w-1:0]    mem_addr;
  logic [opu_pkg::data_w-1:0]    mem_wdata;

  // command word lands on the done of the fetch read
  assign cmd_capture = mem_done && (store_op == opu_pkg::op_cmd_rd);

  opu_sequencer opu_sequencer_i (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .busy           (busy),
    .done           (done),
    .operands_valid (operands_valid),
    .fields         (fields),
    .slot           (slot),
    .slot_last      (slot_last),
    .slot_step      (slot_step),
    .slot_clear     (slot_clear),
    .store_op       (store_op),
    .mem_go         (mem_go),
    .mem_done       (mem_done),
    .result_valid   (result_valid)
  );

  slot_counter slot_counter_i (
    .clk        (clk),
    .rst        (rst),
    .slot_step  (slot_step),
    .slot_clear (slot_clear),
    .slot       (slot),
    .slot_last  (slot_last)
  );

  cmd_decoder cmd_decoder_i (
    .clk     (clk),
    .rst     (rst),
    .capture (cmd_capture),
    .rdata   (rdata),
    .fields  (fields)
  );

  operand_store operand_store_i (
    .clk          (clk),
    .rst          (rst),
    .store_op     (store_op),
    .slot         (slot),
    .fields       (fields),
    .base_addr    (base_addr),
    .rdata        (rdata),
    .capture      (mem_done),
    .result       (result),
    .result_valid (result_valid),
    .operands     (operands),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata)
  );

  mem_port mem_port_i (
    .clk      (clk),
    .rst      (rst),
    .go       (mem_go),
    .store_op (store_op),
    .addr     (mem_addr),
    .wdata    (mem_wdata),
    .mem_req  (mem_req),
    .read_dn  (read_dn),
    .write_dn (write_dn),
    .done     (mem_done)
  );

endmodule

// ==== test/mem_model.sv ====
`timescale 1ns/1ps

module mem_model (
  input  logic              clk,
  input  logic              rst,
  input  opu_pkg::mem_req_t mem_req,
  output logic              read_dn,
  output logic              write_dn,
  output logic [31:0]       rdata
);

  // 1k words, upper address bits ignored
  logic [31:0] mem [0:1023];
  int          rd_count;
  logic [31:0] rng_q;
  logic        pend_q;
  logic        pend_rd_q;
  logic [1:0]  wait_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial begin
    // fill built from the full word index
    for (int i = 0; i < 1024; i++)
      mem[i] = {~i[15:0], i[15:0]} ^ 32'h5a00_00a5;
    rd_count = 0;
    read_dn = 1'b0;
    write_dn = 1'b0;
    rdata = '0;
  end

  always @(posedge clk) begin
    if (rst) begin
      read_dn <= 1'b0;
      write_dn <= 1'b0;
      pend_q <= 1'b0;
      rng_q <= 32'h2fe6_0889;
    end else begin
      read_dn <= 1'b0;
      write_dn <= 1'b0;
      if (mem_req.rd || mem_req.wr) begin
        pend_q <= 1'b1;
        pend_rd_q <= mem_req.rd;
        addr_q <= mem_req.addr;
        wdata_q <= mem_req.wdata;
        // 0..3 extra cycles, so done lands 1 to 4 cycles after the strobe
        wait_q <= rng_q[1:0];
        rng_q <= xorshift(rng_q);
        if (mem_req.rd)
          rd_count <= rd_count + 1;
      end else if (pend_q) begin
        if (wait_q != 2'd0) begin
          wait_q <= wait_q - 2'd1;
        end else begin
          pend_q <= 1'b0;
          if (pend_rd_q) begin
            rdata <= mem[addr_q[9:0]];
            read_dn <= 1'b1;
          end else begin
            mem[addr_q[9:0]] <= wdata_q;
            write_dn <= 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== test/operand_unit_tb.sv ====
`timescale 1ns/1ps

module operand_unit_tb;

  // register file window in memory
  localparam logic [31:0] base = 32'h0000_0100;
  localparam int n_tests = 5;

  logic               clk;
  logic               rst;
  logic               start;
  logic [31:0]        base_addr;
  opu_pkg::mem_req_t  mem_req;
  logic               read_dn;
  logic               write_dn;
  logic [31:0]        rdata;
  logic               busy;
  logic               done;
  logic               operands_valid;
  opu_pkg::operands_t operands;
  logic [31:0]        result;
  logic               result_valid;

  operand_unit operand_unit_i (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .base_addr      (base_addr),
    .mem_req        (mem_req),
    .read_dn        (read_dn),
    .write_dn       (write_dn),
    .rdata          (rdata),
    .busy           (busy),
    .done           (done),
    .operands_valid (operands_valid),
    .operands       (operands),
    .result         (result),
    .result_valid   (result_valid)
  );

  mem_model mem_model_i (
    .clk      (clk),
    .rst      (rst),
    .mem_req  (mem_req),
    .read_dn  (read_dn),
    .write_dn (write_dn),
    .rdata    (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // 400 cycles per test plus reset
  initial begin
    repeat (n_tests * 400 + 8) @(posedge clk);
    $display("watchdog expired before all tests finished");
    $display("TEST FAIL");
    $fatal(1);
  end

  task automatic give_up(input string why);
    $display("%0t: %s", $time, why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  // inputs change 2 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic write_word(input logic [31:0] a, input logic [31:0] v);
    mem_model_i.mem[a[9:0]] = v;
  endtask

  function automatic logic [31:0] read_word(input logic [31:0] a);
    return mem_model_i.mem[a[9:0]];
  endfunction

  task automatic load_reg(input logic [3:0] n, input logic [31:0] v);
    write_word(base + 32'(n), v);
  endtask

  function automatic logic [31:0] reg_value(input logic [3:0] n);
    return read_word(base + 32'(n));
  endfunction

  // ptr bits ordered {cond, dst, src0, src1}
  // flags in the same order with two bits each
  function automatic logic [31:0] make_cmd(input logic [3:0] op, input logic [3:0] c,
                                           input logic [3:0] s1, input logic [3:0] s0,
                                           input logic [3:0] d, input logic [3:0] ptr,
                                           input logic [7:0] flags);
    return {op, flags, ptr, c, d, s0, s1};
  endfunction

  function automatic opu_pkg::operands_t make_ops(input logic [3:0] op, input logic [31:0] c,
                                                  input logic [31:0] s1, input logic [31:0] s0);
    opu_pkg::operands_t o;
    o.opcode = op;
    o.cond = c;
    o.src1 = s1;
    o.src0 = s0;
    return o;
  endfunction

  // stand-in for the execute stage
  function automatic logic [31:0] expected_result(input opu_pkg::operands_t e);
    return (e.src1 + e.src0) ^ {e.cond[15:0], e.cond[31:16]} ^ {28'h0, e.opcode};
  endfunction

  // runs one full command
  // poke fires extra starts while busy
  task automatic run_command(input logic [31:0] cmd, input opu_pkg::operands_t exp,
                             input bit poke, output int reads);
    logic [31:0] ip;
    int          reads_before;
    int          dones;
    int          n;
    ip = reg_value(4'd15);
    write_word(ip, cmd);
    reads_before = mem_model_i.rd_count;
    dones = 0;
    start = 1'b1;
    step();
    start = 1'b0;
    check(busy, 1'b1, "busy after start");
    n = 0;
    while (!operands_valid) begin
      start = poke && (n % 3 == 1);
      step();
      dones += done;
      n++;
      if (n > 300)
        give_up("operands_valid never arrived");
    end
    start = 1'b0;
    check(operands.opcode, exp.opcode, "opcode");
    check(operands.cond, exp.cond, "cond operand");
    check(operands.src1, exp.src1, "src1 operand");
    check(operands.src0, exp.src0, "src0 operand");
    // result a little later than the operands
    step();
    check(operands_valid, 1'b0, "operands_valid single cycle");
    step();
    check(operands.src0, exp.src0, "src0 held while waiting");
    result = expected_result(exp);
    result_valid = 1'b1;
    start = poke;
    step();
    result_valid = 1'b0;
    start = 1'b0;
    n = 0;
    while (busy) begin
      step();
      dones += done;
      n++;
      if (n > 300)
        give_up("command never finished");
    end
    check(done, 1'b1, "done with busy drop");
    repeat (3) begin
      step();
      dones += done;
    end
    check(dones, 1, "done pulses per command");
    reads = mem_model_i.rd_count - reads_before;
    check(reg_value(4'd15), ip + 32'd1, "IP advanced by one");
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      step();
      check({busy, done, operands_valid, mem_req.rd, mem_req.wr}, '0, "idle outputs");
    end
  endtask

  task automatic direct_operands();
    opu_pkg::operands_t exp;
    int                 reads;
    load_reg(4'd1, 32'h1111_0001);
    load_reg(4'd2, 32'h2222_0002);
    load_reg(4'd3, 32'h3333_0003);
    load_reg(4'd4, 32'hdead_beef);
    load_reg(4'd15, 32'h0000_0200);
    exp = make_ops(4'h5, 32'h3333_0003, 32'h1111_0001, 32'h2222_0002);
    run_command(make_cmd(4'h5, 4'd3, 4'd1, 4'd2, 4'd4, 4'b0000, 8'h00), exp, 1'b0, reads);
    check(reg_value(4'd4), expected_result(exp), "result in D");
    check(reg_value(4'd1), 32'h1111_0001, "src1 register untouched");
    // ip, command, three registers
    check(reads, 5, "direct read count");
  endtask

  task automatic pointer_operands();
    opu_pkg::operands_t exp;
    int                 reads;
    load_reg(4'd5, 32'h0000_0300);
    load_reg(4'd6, 32'h0000_0304);
    load_reg(4'd7, 32'h0000_0308);
    load_reg(4'd8, 32'h0000_030c);
    write_word(32'h300, 32'ha5a5_0300);
    write_word(32'h308, 32'h0bad_0308);
    write_word(32'h30c, 32'h0);
    // cond, src1 and dst through pointers with src0 direct
    exp = make_ops(4'h9, 32'h0bad_0308, 32'ha5a5_0300, 32'h0000_0304);
    run_command(make_cmd(4'h9, 4'd7, 4'd5, 4'd6, 4'd8, 4'b1101, 8'h00), exp, 1'b0, reads);
    check(read_word(32'h30c), expected_result(exp), "result through D");
    check(reg_value(4'd8), 32'h0000_030c, "D register unchanged");
    // ip, command, three registers, two pointers, D
    check(reads, 8, "pointer read count");
  endtask

  task automatic post_update();
    opu_pkg::operands_t exp;
    int                 reads;
    load_reg(4'd1, 32'd10);
    load_reg(4'd2, 32'd20);
    load_reg(4'd3, 32'd0);
    // flags {cond keep, dst none, src0 dec, src1 inc}
    exp = make_ops(4'h3, 32'd10, 32'd20, 32'd0);
    run_command(make_cmd(4'h3, 4'd1, 4'd2, 4'd3, 4'd4, 4'b0000, 8'b11_00_10_01), exp, 1'b0,
                reads);
    check(reg_value(4'd1), 32'd10, "keep flag");
    check(reg_value(4'd2), 32'd21, "inc flag");
    check(reg_value(4'd3), 32'hffff_ffff, "dec flag wraps");
    check(reg_value(4'd4), expected_result(exp), "result with updates");
    // D keeps the result since src1 names it
    load_reg(4'd9, 32'h0000_0099);
    load_reg(4'd10, 32'h0000_1000);
    load_reg(4'd11, 32'h0000_0077);
    exp = make_ops(4'h7, 32'h0000_1000, 32'h0000_0099, 32'h0000_0077);
    run_command(make_cmd(4'h7, 4'd10, 4'd9, 4'd11, 4'd9, 4'b0000, 8'b10_00_00_01), exp, 1'b0,
                reads);
    check(reg_value(4'd9), expected_result(exp), "D wins over src1 update");
    check(reg_value(4'd10), 32'h0000_0fff, "cond dec");
    check(reg_value(4'd11), 32'h0000_0077, "src0 no flag");
    // pointer D with post-increment
    load_reg(4'd1, 32'd5);
    load_reg(4'd2, 32'd6);
    load_reg(4'd3, 32'd7);
    load_reg(4'd8, 32'h0000_0314);
    write_word(32'h314, 32'h0);
    exp = make_ops(4'h6, 32'd5, 32'd6, 32'd7);
    run_command(make_cmd(4'h6, 4'd1, 4'd2, 4'd3, 4'd8, 4'b0100, 8'b00_01_00_00), exp, 1'b0,
                reads);
    check(read_word(32'h314), expected_result(exp), "result through D before inc");
    check(reg_value(4'd8), 32'h0000_0315, "D pointer inc");
  endtask

  task automatic forwarding();
    opu_pkg::operands_t exp;
    int                 reads;
    load_reg(4'd12, 32'h0000_0310);
    write_word(32'h310, 32'h1234_5678);
    // one register for all three slots with cond and src0 as pointers
    exp = make_ops(4'h2, 32'h1234_5678, 32'h0000_0310, 32'h1234_5678);
    run_command(make_cmd(4'h2, 4'd12, 4'd12, 4'd12, 4'd4, 4'b1010, 8'h00), exp, 1'b0, reads);
    check(reads, 5, "reads with full forwarding");
    // src0 taken from src1
    load_reg(4'd13, 32'h0000_1313);
    load_reg(4'd14, 32'h0000_1414);
    exp = make_ops(4'h4, 32'h0000_1313, 32'h0000_1414, 32'h0000_1414);
    run_command(make_cmd(4'h4, 4'd13, 4'd14, 4'd14, 4'd4, 4'b0000, 8'h00), exp, 1'b0, reads);
    check(reads, 4, "reads with src1 forwarding");
    check(reg_value(4'd4), expected_result(exp), "result after forwarding");
  endtask

  task automatic control_and_reset();
    opu_pkg::operands_t exp;
    logic [31:0]        ip;
    int                 reads;
    load_reg(4'd1, 32'h0000_0a01);
    load_reg(4'd2, 32'h0000_0a02);
    load_reg(4'd3, 32'h0000_0a03);
    exp = make_ops(4'h1, 32'h0000_0a03, 32'h0000_0a01, 32'h0000_0a02);
    run_command(make_cmd(4'h1, 4'd3, 4'd1, 4'd2, 4'd4, 4'b0000, 8'h00), exp, 1'b1, reads);
    check(reads, 5, "extra starts add no reads");
    ip = reg_value(4'd15);
    // no second command may follow
    check_idle(20);
    check(reg_value(4'd15), ip, "IP after ignored starts");
    // reset in the middle of a command
    write_word(ip, make_cmd(4'h1, 4'd3, 4'd1, 4'd2, 4'd4, 4'b0000, 8'h00));
    start = 1'b1;
    step();
    start = 1'b0;
    repeat (6) step();
    rst = 1'b1;
    repeat (8) step();
    rst = 1'b0;
    check_idle(10);
    load_reg(4'd15, 32'h0000_0240);
    run_command(make_cmd(4'h1, 4'd3, 4'd1, 4'd2, 4'd4, 4'b0000, 8'h00), exp, 1'b0, reads);
    check(reg_value(4'd4), expected_result(exp), "command after reset");
  endtask

  initial begin
    rst = 1'b1;
    start = 1'b0;
    base_addr = base;
    result = '0;
    result_valid = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    check_idle(4);
    direct_operands();
    pointer_operands();
    post_update();
    forwarding();
    control_and_reset();
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== operand_unit.f ====
verilog/opu_pkg.sv
verilog/slot_counter.sv
verilog/cmd_decoder.sv
verilog/operand_store.sv
verilog/mem_port.sv
verilog/opu_sequencer.sv
verilog/operand_unit.sv
test/mem_model.sv
test/operand_unit_tb.sv
